// ==== vlog.f ====
hw/scale_pkg.sv
hw/scale_regs.sv
hw/scale_apply.sv
hw/requant.sv
hw/scale_requant_top.sv
verif/tb_clock.sv
verif/scale_requant_props.sv
verif/scale_requant_tb.sv

// ==== Bender.yml ====
package:
  name: scale_requant

sources:
  - files:
      - hw/scale_pkg.sv
      - hw/scale_regs.sv
      - hw/scale_apply.sv
      - hw/requant.sv
      - hw/scale_requant_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/scale_requant_props.sv
      - verif/scale_requant_tb.sv

// ==== verif/scale_requant_tb.sv ====
`default_nettype none

module scale_requant_tb;

  import scale_pkg::*;

  localparam int psum_width = 24;
  localparam int out_width = 8;
  localparam int reset_cycles = 16;
  // cycles a sample may take to leave the pipeline
  localparam int drain_limit = 20;
  // budget per test with worst case gaps in the stream test
  localparam int test_cycles = 40 + 80 + 80 + 60 + 850 + 30;
  localparam longint watchdog_time = 40 * (reset_cycles + test_cycles + 50);

  logic                                clk;
  logic                                reset;
  logic                                scale_set;
  logic                                mode;
  scale_word_u                         scale_word;
  logic [7:0]                          scale_reg_start;
  logic [7:0]                          scale_reg_size;
  logic                                psum_valid;
  logic [5:0]                          out_sa_row_idx;
  logic [sa_row_num*psum_width-1:0]    psums;
  logic                                out_valid;
  logic [sa_row_num*out_width-1:0]     out_data;
  logic [5:0]                          out_row_idx;

  // reference copy of the 64 scale registers
  scale_set_t model_regs [scale_sets_num];
  // one expected output per accepted sample
  logic [5:0]                      exp_idx [$];
  logic [sa_row_num*out_width-1:0] exp_data [$];
  logic [5:0]                      mon_idx;
  logic [sa_row_num*out_width-1:0] mon_data;
  int errors;
  int checks;

  tb_clock #(.period(40)) i_clock (.clk(clk));

  scale_requant_top i_dut (
    .clk             (clk),
    .reset           (reset),
    .scale_set       (scale_set),
    .mode            (mode),
    .scale_word      (scale_word),
    .scale_reg_start (scale_reg_start),
    .scale_reg_size  (scale_reg_size),
    .psum_valid      (psum_valid),
    .out_sa_row_idx  (out_sa_row_idx),
    .psums           (psums),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .out_row_idx     (out_row_idx)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: time %0t: %s got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // psum * (mult + 1), round half up, >>> rank, clamp to 8 bits
  function automatic logic [7:0] requant_ref(input logic [23:0] psum, input scale_set_t s);
    longint p;
    longint f;
    int r;
    p = longint'($signed(psum));
    f = longint'(s.mult) + 1;
    r = int'(s.rank);
    p = p * f;
    if (r >= 32) begin
      p = (p < 0) ? -1 : 0;
    end else begin
      if (r > 0) p = p + (longint'(1) << (r - 1));
      p = p >>> r;
    end
    if (p > 127) p = 127;
    if (p < -128) p = -128;
    return p[7:0];
  endfunction

  // registers numbered 1..64
  // mode 1 only knows starts 1 and 33
  task automatic model_write(input logic m, input scale_word_u w, input int start,
                             input int size);
    for (int k = 1; k <= scale_sets_num; k++) begin
      if (k >= start && k < start + size) begin
        if (!m) model_regs[k-1] = {8'd0, w.ranks[k-1]};
        else if (start == 1 && k <= 32) model_regs[k-1] = w.sets[k-1];
        else if (start == 33 && k >= 33) model_regs[k-1] = w.sets[k-33];
        else model_regs[k-1] = '0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one cycle of inputs set on the falling edge
  task automatic drive(input logic wr, input logic m, input scale_word_u w, input int start,
                       input int size, input logic pv, input logic [5:0] idx,
                       input logic [95:0] ps);
    logic [31:0] exp;
    @(negedge clk);
    scale_set = wr;
    mode = m;
    scale_word = w;
    scale_reg_start = 8'(start);
    scale_reg_size = 8'(size);
    psum_valid = pv;
    out_sa_row_idx = idx;
    psums = ps;
    // sample sees the sets from before a write in the same cycle
    if (pv && idx != 6'd0) begin
      for (int c = 0; c < sa_row_num; c++) begin
        exp[c*8 +: 8] = requant_ref(ps[c*24 +: 24],
                                    model_regs[c*row_num_in_sa + int'(idx) - 1]);
      end
      exp_idx.push_back(idx);
      exp_data.push_back(exp);
    end
    if (wr) model_write(m, w, start, size);
  endtask

  task automatic write_scales(input logic m, input scale_word_u w, input int start,
                              input int size);
    drive(1'b1, m, w, start, size, 1'b0, 6'd0, '0);
  endtask

  task automatic send(input logic [5:0] idx, input logic [95:0] ps);
    drive(1'b0, 1'b0, '0, 0, 0, 1'b1, idx, ps);
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, '0, 0, 0, 1'b0, 6'd0, '0);
  endtask

  // magnitudes from a few units up to the full 24 bits
  function automatic logic [95:0] rand_psums();
    logic [95:0] ps;
    int v;
    for (int c = 0; c < 4; c++) begin
      v = $signed($urandom) >>> $urandom_range(31, 8);
      ps[c*24 +: 24] = 24'(v);
    end
    return ps;
  endfunction

  function automatic scale_word_u random_ranks(input int max_rank);
    scale_word_u w;
    for (int k = 0; k < 64; k++) w.ranks[k] = 8'($urandom_range(max_rank, 0));
    return w;
  endfunction

  function automatic scale_word_u random_sets(input int max_rank);
    scale_word_u w;
    for (int k = 0; k < 32; k++) begin
      w.sets[k].mult = 8'($urandom);
      w.sets[k].rank = 8'($urandom_range(max_rank, 0));
    end
    return w;
  endfunction

  task automatic sweep_rows();
    for (int i = 1; i <= row_num_in_sa; i++) send(6'(i), rand_psums());
  endtask

  // idle until every queued sample came out
  task automatic drain();
    int n;
    n = 0;
    idle();
    while (exp_idx.size() != 0 && n < drain_limit) begin
      idle();
      n++;
    end
    if (exp_idx.size() != 0) begin
      $display("%0d samples never came out of the pipeline by time %0t",
               exp_idx.size(), $time);
      errors += exp_idx.size();
      exp_idx.delete();
      exp_data.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    repeat (4) idle();
    sweep_rows();
    drain();
  endtask

  task automatic test_mode0();
    write_scales(1'b0, random_ranks(12), 1, 64);
    sweep_rows();
    // partial write leaves the other ranks as they were
    write_scales(1'b0, random_ranks(12), 10, 5);
    sweep_rows();
    drain();
  endtask

  task automatic test_mode1();
    write_scales(1'b1, random_sets(20), 1, 32);
    write_scales(1'b1, random_sets(20), 33, 32);
    sweep_rows();
    // odd start clears registers 5..8
    write_scales(1'b1, random_sets(20), 5, 4);
    sweep_rows();
    drain();
  endtask

  task automatic test_saturation();
    scale_word_u w;
    for (int k = 0; k < 32; k++) w.sets[k] = {8'd255, 8'd0};
    write_scales(1'b1, w, 1, 32);
    write_scales(1'b1, w, 33, 32);
    send(6'd1, {24'h7fffff, 24'h800000, 24'd1000, -24'sd1000});
    send(6'd7, {24'h000080, 24'hffff80, 24'h000000, 24'hffffff});
    // odd rows rank 1, even rows rank 2
    for (int k = 0; k < 64; k++) w.ranks[k] = (k % 2 == 1) ? 8'd2 : 8'd1;
    write_scales(1'b0, w, 1, 64);
    send(6'd1, {-24'sd3, -24'sd1, 24'sd3, -24'sd2});
    send(6'd2, {-24'sd5, -24'sd6, -24'sd2, 24'sd6});
    drain();
  endtask

  task automatic test_gating_stream();
    write_scales(1'b1, random_sets(16), 1, 32);
    write_scales(1'b1, random_sets(16), 33, 32);
    // empty slot, then a dropped valid
    drive(1'b0, 1'b0, '0, 0, 0, 1'b1, 6'd0, rand_psums());
    drive(1'b0, 1'b0, '0, 0, 0, 1'b0, 6'd5, rand_psums());
    repeat (4) idle();
    for (int n = 0; n < 200; n++) begin
      if ($urandom_range(3, 0) == 0) repeat ($urandom_range(3, 1)) idle();
      send(6'($urandom_range(16, 1)), rand_psums());
    end
    drain();
  endtask

  task automatic test_write_then_read();
    logic [95:0] ps;
    write_scales(1'b0, random_ranks(12), 1, 64);
    for (int i = 3; i <= 16; i += 13) begin
      ps = rand_psums();
      drive(1'b1, 1'b0, random_ranks(12), 1, 64, 1'b1, 6'(i), ps);
      send(6'(i), ps);
    end
    drain();
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor, watchdog, verdict
  //////////////////////////////////////////////////////////////////////

  // registered outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!reset && out_valid === 1'b1) begin
      if (exp_idx.size() == 0) begin
        $display("out_valid came with no sample pending at time %0t", $time);
        errors++;
      end else begin
        mon_idx = exp_idx.pop_front();
        mon_data = exp_data.pop_front();
        check("out_row_idx", 32'(out_row_idx), 32'(mon_idx));
        for (int c = 0; c < sa_row_num; c++) begin
          check($sformatf("out_data ch%0d row %0d", c, mon_idx),
                32'(out_data[c*8 +: 8]), 32'(mon_data[c*8 +: 8]));
        end
      end
    end
  end

  initial begin
    #(watchdog_time);
    $display("watchdog expired after %0t, the run did not finish", watchdog_time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h228238e2));
    errors = 0;
    checks = 0;
    reset = 1'b1;
    scale_set = 1'b0;
    mode = 1'b0;
    scale_word = '0;
    scale_reg_start = '0;
    scale_reg_size = '0;
    psum_valid = 1'b0;
    out_sa_row_idx = '0;
    psums = '0;
    for (int k = 0; k < scale_sets_num; k++) model_regs[k] = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_mode0();
    test_mode1();
    test_saturation();
    test_gating_stream();
    test_write_then_read();
    // failed pipeline timing assertions count as errors
    errors += i_dut.i_props.fails;
    $display("run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0 && checks > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/scale_requant_props.sv ====
`default_nettype none

module scale_requant_props (
  input wire       clk,
  input wire       reset,
  input wire       psum_valid,
  input wire [5:0] out_sa_row_idx,
  input wire       out_valid
);

  // a sample the pipeline takes in
  logic accept;
  // failed assertion count
  int fails;

  assign accept = psum_valid && (out_sa_row_idx != 6'd0);

  initial fails = 0;

  // quiet output through reset and the cycle after it
  a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high during reset or on the cycle after it");
      fails++;
    end

  // fixed two cycle latency
  a_latency: assert property (@(posedge clk) disable iff (reset) accept |-> ##2 out_valid)
    else begin
      $error("accepted sample not followed by out_valid two cycles later");
      fails++;
    end

  // every output traces back to an accepted sample
  a_no_spurious: assert property (@(posedge clk) disable iff (reset)
                                  out_valid |-> $past(accept, 2))
    else begin
      $error("out_valid without an accepted sample two cycles earlier");
      fails++;
    end

endmodule

bind scale_requant_top scale_requant_props i_props (
  .clk            (clk),
  .reset          (reset),
  .psum_valid     (psum_valid),
  .out_sa_row_idx (out_sa_row_idx),
  .out_valid      (out_valid)
);

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none

module tb_clock #(
  parameter int period = 40
) (
  output logic clk
);

  // free running, starts low
  initial clk = 1'b0;

  // half period per phase
  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== hw/scale_requant_top.sv ====
`default_nettype none

module scale_requant_top #(
  parameter int psum_width = 24,
  parameter int out_width = 8
) (
  input  wire                                            clk,
  input  wire                                            reset,
  // scale write port
  input  wire                                            scale_set,
  input  wire                                            mode,
  input  wire scale_pkg::scale_word_u                    scale_word,
  input  wire [7:0]                                      scale_reg_start,
  input  wire [7:0]                                      scale_reg_size,
  // partial sums from the array, channel 0 low
  input  wire                                            psum_valid,
  input  wire [5:0]                                      out_sa_row_idx,
  input  wire [scale_pkg::sa_row_num*psum_width-1:0]     psums,
  // requantized row
  output logic                                           out_valid,
  output logic signed [scale_pkg::sa_row_num*out_width-1:0] out_data,
  output logic [5:0]                                     out_row_idx
);

  import scale_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // inter-stage nets
  //////////////////////////////////////////////////////////////////////

  // sets for the row now on the bus
  scale_set_t [sa_row_num-1:0]                  scale_sets;
  // stage 1 to stage 2
  logic                                         prod_valid;
  logic signed [sa_row_num*(psum_width+9)-1:0]  prods;
  logic [sa_row_num*scale_width-1:0]            ranks;
  logic [5:0]                                   prod_row_idx;

  // lookup, zero latency
  scale_regs i_scale_regs (
    .clk             (clk),
    .reset           (reset),
    .scale_set       (scale_set),
    .mode            (mode),
    .scale_word      (scale_word),
    .scale_reg_start (scale_reg_start),
    .scale_reg_size  (scale_reg_size),
    .out_sa_row_idx  (out_sa_row_idx),
    .scale_sets      (scale_sets)
  );

  // stage 1, multiply
  scale_apply #(
    .psum_width (psum_width)
  ) i_scale_apply (
    .clk            (clk),
    .reset          (reset),
    .psum_valid     (psum_valid),
    .out_sa_row_idx (out_sa_row_idx),
    .psums          (psums),
    .scale_sets     (scale_sets),
    .prod_valid     (prod_valid),
    .prods          (prods),
    .ranks          (ranks),
    .prod_row_idx   (prod_row_idx)
  );

  // stage 2, round, shift, saturate
  requant #(
    .psum_width (psum_width),
    .out_width  (out_width)
  ) i_requant (
    .clk          (clk),
    .reset        (reset),
    .prod_valid   (prod_valid),
    .prods        (prods),
    .ranks        (ranks),
    .prod_row_idx (prod_row_idx),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_row_idx  (out_row_idx)
  );

endmodule

`default_nettype wire

// ==== hw/requant.sv ====
`default_nettype none

module requant #(
  parameter int psum_width = 24,
  parameter int out_width = 8
) (
  input  wire                                                 clk,
  input  wire                                                 reset,
  input  wire                                                 prod_valid,
  input  wire [scale_pkg::sa_row_num*(psum_width+9)-1:0]      prods,
  input  wire [scale_pkg::sa_row_num*scale_pkg::scale_width-1:0] ranks,
  input  wire [5:0]                                           prod_row_idx,
  output logic                                                out_valid,
  output logic signed [scale_pkg::sa_row_num*out_width-1:0]   out_data,
  output logic [5:0]                                          out_row_idx
);

  import scale_pkg::*;

  localparam int prod_width = psum_width + 9;
  // one guard bit for the rounding add
  localparam int sum_width = prod_width + 1;
  // ranks from here on shift everything out
  localparam int rank_fill = 32;
  localparam logic signed [sum_width-1:0] sat_max = sum_width'((1 << (out_width - 1)) - 1);
  // ~(2^k - 1) is -2^k
  localparam logic signed [sum_width-1:0] sat_min = ~sat_max;

  logic signed [sum_width-1:0] sum_ch [sa_row_num];
  logic signed [sum_width-1:0] shift_ch [sa_row_num];
  logic signed [sum_width-1:0] sat_ch [sa_row_num];

  always_comb begin
    logic [scale_width-1:0] rank_c;
    logic [sum_width-1:0]   half_c;
    logic                   sign_c;
    for (int c = 0; c < sa_row_num; c++) begin
      rank_c = ranks[c*scale_width +: scale_width];
      sign_c = prods[c*prod_width+prod_width-1];
      // round half up, 2^(rank-1) added before the shift
      half_c = (rank_c == '0) ? '0 : (sum_width'(1) << (rank_c - 8'd1));
      sum_ch[c] = $signed({sign_c, prods[c*prod_width +: prod_width]}) + $signed(half_c);
      if (rank_c >= scale_width'(rank_fill)) begin
        shift_ch[c] = {sum_width{sign_c}};
      end else begin
        shift_ch[c] = sum_ch[c] >>> rank_c[4:0];
      end
      // clamp into signed out_width
      if (shift_ch[c] > sat_max) begin
        sat_ch[c] = sat_max;
      end else if (shift_ch[c] < sat_min) begin
        sat_ch[c] = sat_min;
      end else begin
        sat_ch[c] = shift_ch[c];
      end
    end
  end

  // stage 2 valid
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      for (int c = 0; c < sa_row_num; c++) begin
        out_data[c*out_width +: out_width] <= sat_ch[c][out_width-1:0];
      end
      out_row_idx <= prod_row_idx;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scale_apply.sv ====
`default_nettype none

module scale_apply #(
  parameter int psum_width = 24
) (
  input  wire                                                 clk,
  input  wire                                                 reset,
  input  wire                                                 psum_valid,
  input  wire [5:0]                                           out_sa_row_idx,
  input  wire [scale_pkg::sa_row_num*psum_width-1:0]          psums,
  input  wire scale_pkg::scale_set_t [scale_pkg::sa_row_num-1:0] scale_sets,
  output logic                                                prod_valid,
  output logic signed [scale_pkg::sa_row_num*(psum_width+9)-1:0] prods,
  output logic [scale_pkg::sa_row_num*scale_pkg::scale_width-1:0] ranks,
  output logic [5:0]                                          prod_row_idx
);

  import scale_pkg::*;

  // 9 extra bits hold the factor of up to 256
  localparam int prod_width = psum_width + 9;

  // idx 0 marks an empty slot from the array
  logic accept;
  logic signed [prod_width-1:0] prod_ch [sa_row_num];

  assign accept = psum_valid && (out_sa_row_idx != 6'd0);

  // psum * (mult + 1), both operands taken to product width
  always_comb begin
    logic [8:0] factor;
    for (int c = 0; c < sa_row_num; c++) begin
      factor = {1'b0, scale_sets[c].mult} + 9'd1;
      prod_ch[c] = $signed({{9{psums[c*psum_width+psum_width-1]}},
                            psums[c*psum_width +: psum_width]}) *
                   $signed({{(prod_width-9){1'b0}}, factor});
    end
  end

  // stage 1 valid
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= accept;
    end
  end

  // payload follows the sample, rank rides along for stage 2
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int c = 0; c < sa_row_num; c++) begin
        prods[c*prod_width +: prod_width] <= prod_ch[c];
        ranks[c*scale_width +: scale_width] <= scale_sets[c].rank;
      end
      prod_row_idx <= out_sa_row_idx;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scale_regs.sv ====
`default_nettype none

module scale_regs (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         scale_set,
  input  wire                                         mode,
  input  wire scale_pkg::scale_word_u                 scale_word,
  input  wire [7:0]                                   scale_reg_start,
  input  wire [7:0]                                   scale_reg_size,
  input  wire [5:0]                                   out_sa_row_idx,
  output scale_pkg::scale_set_t [scale_pkg::sa_row_num-1:0] scale_sets
);

  import scale_pkg::*;

  // register k holds scale set of register number k+1
  scale_set_t regs_q [scale_sets_num];

  // write enables per register
  logic [scale_sets_num-1:0] wr_mask;
  // word expanded to one set per register
  scale_set_t wr_sets [scale_sets_num];

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // range start .. start+size-1, numbered from 1
  // 9 bit math so start+size cannot wrap
  always_comb begin
    logic [8:0] range_end;
    range_end = {1'b0, scale_reg_start} + {1'b0, scale_reg_size};
    for (int k = 0; k < scale_sets_num; k++) begin
      wr_mask[k] = (9'(k + 1) >= {1'b0, scale_reg_start}) && (9'(k + 1) < range_end);
    end
  end

  // mode 0: zero-extended rank, one per register
  // mode 1: 32 full sets into the low or high half
  always_comb begin
    for (int k = 0; k < scale_sets_num; k++) begin
      if (!mode) begin
        wr_sets[k].mult = '0;
        wr_sets[k].rank = scale_word.ranks[k];
      end else if ((scale_reg_start == 8'd1) && (k < scale_word_sets)) begin
        wr_sets[k] = scale_word.sets[k];
      end else if ((scale_reg_start == 8'(scale_word_sets + 1)) &&
                   (k >= scale_word_sets)) begin
        wr_sets[k] = scale_word.sets[k-scale_word_sets];
      end else begin
        // unsupported mode 1 start, masked regs cleared
        wr_sets[k] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < scale_sets_num; k++) begin
        regs_q[k] <= '0;
      end
    end else if (scale_set) begin
      for (int k = 0; k < scale_sets_num; k++) begin
        if (wr_mask[k]) begin
          regs_q[k] <= wr_sets[k];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // channel c takes register c*16 + idx
  // idx 0 means no sum, sets read as zero
  always_comb begin
    logic [5:0] row_ofs;
    row_ofs = out_sa_row_idx - 6'd1;
    for (int c = 0; c < sa_row_num; c++) begin
      if ((out_sa_row_idx == 6'd0) || (out_sa_row_idx > 6'(row_num_in_sa))) begin
        scale_sets[c] = '0;
      end else begin
        scale_sets[c] = regs_q[c*row_num_in_sa + int'(row_ofs)];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/scale_pkg.sv ====
`default_nettype none

package scale_pkg;

  //////////////////////////////////////////////////////////////////////
  // conv core geometry
  //////////////////////////////////////////////////////////////////////

  // systolic arrays in the core
  localparam int sa_row_num = 4;
  // rows inside one array
  localparam int row_num_in_sa = 16;
  // rank field, also one mode 0 scale
  localparam int scale_width = 8;
  // full set, multiplier byte over rank byte
  localparam int scale_set_width = 16;
  // one register per row position
  localparam int scale_sets_num = sa_row_num * row_num_in_sa;
  // scale word as delivered by the loader
  localparam int scale_word_width = 512;
  // sets carried by one mode 1 word
  localparam int scale_word_sets = scale_word_width / scale_set_width;

  //////////////////////////////////////////////////////////////////////
  // scale set and scale word layouts
  //////////////////////////////////////////////////////////////////////

  // psum * (mult + 1), then >>> rank
  typedef struct packed {
    logic [scale_set_width-scale_width-1:0] mult;
    logic [scale_width-1:0]                 rank;
  } scale_set_t;

  // same 512 bits, two decodings
  // mode 0 reads ranks, entry k for register k+1
  // mode 1 reads sets, entry k for register start+k
  typedef union packed {
    logic [scale_sets_num-1:0][scale_width-1:0] ranks;
    scale_set_t [scale_word_sets-1:0]           sets;
  } scale_word_u;

endpackage

`default_nettype wire
